// ==== emu_ctrl.f ====
src/emu_pkg.sv
src/wb_csr_bridge.sv
src/emu_csr_regs.sv
src/scan_chain_ctrl.sv
src/emu_ctrl.sv
verif/emu_ctrl_sva.sv
verif/emu_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: emu_ctrl

sources:
  - src/emu_pkg.sv
  - src/wb_csr_bridge.sv
  - src/emu_csr_regs.sv
  - src/scan_chain_ctrl.sv
  - src/emu_ctrl.sv
  - target: test
    files:
      - verif/emu_ctrl_sva.sv
      - verif/emu_ctrl_tb.sv

// ==== verif/emu_ctrl_tb.sv ====
`timescale 1ns/1ps

module emu_ctrl_tb;

    typedef enum logic [3:0] {
        OP_WR,      // bus write
        OP_RD,      // bus read and compare
        OP_POLL,    // read until the value matches
        OP_TICK,    // hold tick high for data cycles
        OP_TRIG,    // drive trig[addr] to data[0]
        OP_RUN,     // compare run_mode
        OP_MODE,    // compare scan_mode
        OP_RST,     // compare model_rst
        OP_LOAD,    // random words into the chain model
        OP_FILL,    // random words into SCAN_DATA
        OP_SCAN     // SCAN_DATA and chain against expected words
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [3:0]  test;
        logic [9:0]  addr;
        logic [31:0] data;
    } entry_t;

    logic                            host_clk;
    logic                            host_rst;
    emu_pkg::wb_req_t                wb_req;
    emu_pkg::wb_rsp_t                wb_rsp;
    logic                            tick;
    logic [63:0]                     ff_do;
    logic [emu_pkg::TRIG_COUNT-1:0]  trig;
    logic                            run_mode;
    logic                            scan_mode;
    logic                            ff_se;
    logic [63:0]                     ff_di;
    logic [emu_pkg::RESET_COUNT-1:0] model_rst;

    // Chain model with word 0 at the output end
    logic [63:0] chain      [emu_pkg::FF_COUNT];
    logic [63:0] load_words [emu_pkg::FF_COUNT];
    logic [63:0] exp_words  [emu_pkg::FF_COUNT];
    logic        load_req;

    entry_t      steps [$];
    string       test_name [7] = '{"reset values", "register read-back", "tick counter preset",
                                   "step budget", "trigger pause", "scan capture", "scan restore"};
    logic [31:0] lcg_state = 32'hdc9d8d89;
    int          cycles = 0;
    int          cycle_limit = 200;
    int          checks;
    int          errors;
    int          test_errors;

    emu_ctrl i_dut (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .tick      (tick),
        .ff_do     (ff_do),
        .trig      (trig),
        .run_mode  (run_mode),
        .scan_mode (scan_mode),
        .ff_se     (ff_se),
        .ff_di     (ff_di),
        .model_rst (model_rst)
    );

    initial host_clk = 1'b0;
    always #2 host_clk = ~host_clk;

    always @(posedge host_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    assign ff_do = chain[0];

    always @(posedge host_clk) begin
        if (load_req) begin
            for (int i = 0; i < emu_pkg::FF_COUNT; i++) begin
                chain[i] <= load_words[i];
            end
        end else if (ff_se) begin
            for (int i = 0; i < emu_pkg::FF_COUNT - 1; i++) begin
                chain[i] <= chain[i + 1];
            end
            chain[emu_pkg::FF_COUNT-1] <= ff_di;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic bus_access(input logic we, input logic [9:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = {addr, 2'b00};
        wb_req.dat_w = wdata;
        do begin
            @(negedge host_clk);
            waited++;
        end while (!wb_rsp.ack && waited < 16);
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat_r;
        end else begin
            report_failure($sformatf("no Wishbone ack for the access at word 0x%03h", addr));
        end
        // Request stays up through the edge that samples ack
        @(negedge host_clk);
        wb_req = '0;
    endtask

    task automatic load_chain();
        for (int i = 0; i < emu_pkg::FF_COUNT; i++) begin
            load_words[i][63:32] = next_random();
            load_words[i][31:0]  = next_random();
            exp_words[i]         = load_words[i];
        end
        load_req = 1'b1;
        @(negedge host_clk);
        load_req = 1'b0;
    endtask

    task automatic fill_buffer();
        logic [31:0] unused;
        for (int i = 0; i < emu_pkg::FF_COUNT; i++) begin
            exp_words[i][31:0]  = next_random();
            exp_words[i][63:32] = next_random();
            bus_access(1'b1, 10'(emu_pkg::SCAN_DATA + 2 * i), exp_words[i][31:0], unused);
            bus_access(1'b1, 10'(emu_pkg::SCAN_DATA + 2 * i + 1), exp_words[i][63:32], unused);
        end
    endtask

    task automatic check_scan();
        logic [31:0] lo;
        logic [31:0] hi;
        for (int i = 0; i < emu_pkg::FF_COUNT; i++) begin
            bus_access(1'b0, 10'(emu_pkg::SCAN_DATA + 2 * i), '0, lo);
            bus_access(1'b0, 10'(emu_pkg::SCAN_DATA + 2 * i + 1), '0, hi);
            check_value($sformatf("SCAN_DATA word %0d", i), {hi, lo}, exp_words[i]);
            check_value($sformatf("chain word %0d", i), chain[i], exp_words[i]);
        end
    endtask

    task automatic add_step(input op_e op, input int test, input int addr,
                            input logic [31:0] data);
        entry_t e;
        e.op   = op;
        e.test = 4'(test);
        e.addr = 10'(addr);
        e.data = data;
        steps.push_back(e);
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] rdata;
        int          polls;
        case (e.op)
            OP_WR: bus_access(1'b1, e.addr, e.data, rdata);
            OP_RD: begin
                bus_access(1'b0, e.addr, '0, rdata);
                check_value($sformatf("dat_r at word 0x%03h", e.addr), rdata, e.data);
            end
            OP_POLL: begin
                polls = 0;
                do begin
                    bus_access(1'b0, e.addr, '0, rdata);
                    polls++;
                end while (rdata !== e.data && polls < 12);
                checks++;
                assert (rdata === e.data) else
                    report_failure($sformatf("word 0x%03h never reached its idle value", e.addr));
            end
            OP_TICK: begin
                tick = 1'b1;
                repeat (e.data) @(negedge host_clk);
                tick = 1'b0;
            end
            OP_TRIG: trig[e.addr] = e.data[0];
            OP_RUN: check_value("run_mode", run_mode, e.data);
            OP_MODE: check_value("scan_mode", scan_mode, e.data);
            OP_RST: check_value("model_rst", model_rst, e.data);
            OP_LOAD: load_chain();
            OP_FILL: fill_buffer();
            OP_SCAN: check_scan();
            default: report_failure("unknown table operation");
        endcase
    endtask

    task automatic build_table();
        add_step(OP_RD, 0, emu_pkg::RUN_CTRL, 32'h0);
        add_step(OP_RD, 0, emu_pkg::TICK_STEP, 32'h0);
        add_step(OP_RD, 0, emu_pkg::TICK_CNT_LO, 32'h0);
        add_step(OP_RD, 0, emu_pkg::TICK_CNT_HI, 32'h0);
        add_step(OP_RD, 0, emu_pkg::SCAN_CTRL, 32'h0);
        add_step(OP_RD, 0, emu_pkg::TRIG_STAT, 32'h0);
        add_step(OP_RD, 0, emu_pkg::TRIG_EN, 32'h0);
        add_step(OP_RD, 0, emu_pkg::RESET_CTRL, 32'h0);
        add_step(OP_RUN, 0, 0, 32'h0);
        add_step(OP_MODE, 0, 0, 32'h0);
        add_step(OP_RST, 0, 0, 32'h0);
        // Only 48 triggers and 16 resets exist
        add_step(OP_WR, 1, emu_pkg::TRIG_EN, 32'ha5a5_5a5a);
        add_step(OP_WR, 1, emu_pkg::TRIG_EN + 1, 32'hffff_ffff);
        add_step(OP_WR, 1, emu_pkg::TRIG_EN + 2, 32'hffff_ffff);
        add_step(OP_RD, 1, emu_pkg::TRIG_EN, 32'ha5a5_5a5a);
        add_step(OP_RD, 1, emu_pkg::TRIG_EN + 1, 32'h0000_ffff);
        add_step(OP_RD, 1, emu_pkg::TRIG_EN + 2, 32'h0);
        add_step(OP_WR, 1, emu_pkg::RESET_CTRL, 32'h1234_c3a5);
        add_step(OP_WR, 1, emu_pkg::RESET_CTRL + 1, 32'hffff_ffff);
        add_step(OP_RD, 1, emu_pkg::RESET_CTRL, 32'h0000_c3a5);
        add_step(OP_RD, 1, emu_pkg::RESET_CTRL + 1, 32'h0);
        add_step(OP_RST, 1, 0, 32'h0000_c3a5);
        // Scan mode bit alone does not resume the model
        add_step(OP_WR, 1, emu_pkg::RUN_CTRL, 32'h2);
        add_step(OP_RD, 1, emu_pkg::RUN_CTRL, 32'h2);
        add_step(OP_MODE, 1, 0, 32'h1);
        add_step(OP_RUN, 1, 0, 32'h0);
        add_step(OP_WR, 1, emu_pkg::RUN_CTRL, 32'h0);
        add_step(OP_MODE, 1, 0, 32'h0);
        add_step(OP_WR, 1, emu_pkg::TRIG_EN, 32'h0);
        add_step(OP_WR, 1, emu_pkg::TRIG_EN + 1, 32'h0);
        add_step(OP_RD, 1, emu_pkg::TRIG_EN + 1, 32'h0);
        // Preset near a carry into the high word
        add_step(OP_WR, 2, emu_pkg::TICK_CNT_LO, 32'hffff_fffe);
        add_step(OP_WR, 2, emu_pkg::TICK_CNT_HI, 32'h0000_0012);
        add_step(OP_TICK, 2, 0, 32'd5);
        add_step(OP_RD, 2, emu_pkg::TICK_CNT_LO, 32'hffff_fffe);
        add_step(OP_RD, 2, emu_pkg::TICK_CNT_HI, 32'h0000_0012);
        add_step(OP_WR, 2, emu_pkg::RUN_CTRL, 32'h1);
        add_step(OP_RUN, 2, 0, 32'h1);
        add_step(OP_TICK, 2, 0, 32'd5);
        add_step(OP_RD, 2, emu_pkg::TICK_CNT_LO, 32'h0000_0003);
        add_step(OP_RD, 2, emu_pkg::TICK_CNT_HI, 32'h0000_0013);
        add_step(OP_WR, 2, emu_pkg::RUN_CTRL, 32'h0);
        add_step(OP_RUN, 2, 0, 32'h1);
        add_step(OP_TICK, 2, 0, 32'd1);
        add_step(OP_RUN, 2, 0, 32'h0);
        add_step(OP_RD, 2, emu_pkg::TICK_CNT_LO, 32'h0000_0004);
        // Budget of 7 against 20 ticks
        add_step(OP_WR, 3, emu_pkg::TICK_CNT_LO, 32'h0);
        add_step(OP_WR, 3, emu_pkg::TICK_CNT_HI, 32'h0);
        add_step(OP_WR, 3, emu_pkg::TICK_STEP, 32'd7);
        add_step(OP_RD, 3, emu_pkg::TICK_STEP, 32'd7);
        add_step(OP_WR, 3, emu_pkg::RUN_CTRL, 32'h1);
        add_step(OP_TICK, 3, 0, 32'd20);
        add_step(OP_RUN, 3, 0, 32'h0);
        add_step(OP_RD, 3, emu_pkg::TICK_CNT_LO, 32'd7);
        add_step(OP_RD, 3, emu_pkg::TICK_CNT_HI, 32'h0);
        add_step(OP_RD, 3, emu_pkg::TICK_STEP, 32'h0);
        // Trigger 40 enabled and trigger 5 only observed
        add_step(OP_WR, 4, emu_pkg::TRIG_EN + 1, 32'h0000_0100);
        add_step(OP_WR, 4, emu_pkg::RUN_CTRL, 32'h1);
        add_step(OP_TRIG, 4, 5, 32'h1);
        add_step(OP_TICK, 4, 0, 32'd3);
        add_step(OP_RUN, 4, 0, 32'h1);
        add_step(OP_RD, 4, emu_pkg::TRIG_STAT, 32'h0000_0020);
        add_step(OP_TRIG, 4, 5, 32'h0);
        add_step(OP_TRIG, 4, 40, 32'h1);
        add_step(OP_TICK, 4, 0, 32'd1);
        add_step(OP_RUN, 4, 0, 32'h0);
        add_step(OP_RD, 4, emu_pkg::TRIG_STAT + 1, 32'h0000_0100);
        add_step(OP_RD, 4, emu_pkg::TRIG_STAT, 32'h0);
        add_step(OP_TRIG, 4, 40, 32'h0);
        add_step(OP_WR, 4, emu_pkg::TRIG_EN + 1, 32'h0);
        add_step(OP_LOAD, 5, 0, 32'h0);
        add_step(OP_WR, 5, emu_pkg::SCAN_CTRL, 32'h1);
        add_step(OP_POLL, 5, emu_pkg::SCAN_CTRL, 32'h0);
        add_step(OP_SCAN, 5, 0, 32'h0);
        add_step(OP_FILL, 6, 0, 32'h0);
        add_step(OP_WR, 6, emu_pkg::SCAN_CTRL, 32'h3);
        add_step(OP_POLL, 6, emu_pkg::SCAN_CTRL, 32'h0);
        add_step(OP_SCAN, 6, 0, 32'h0);
    endtask

    initial begin
        host_rst    = 1'b1;
        wb_req      = '0;
        tick        = 1'b0;
        trig        = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        // Chain model is cleared while reset is held
        for (int i = 0; i < emu_pkg::FF_COUNT; i++) begin
            load_words[i] = '0;
        end
        load_req    = 1'b1;
        build_table();
        cycle_limit = 40 * steps.size() + 200;
        repeat (3) @(negedge host_clk);
        host_rst = 1'b0;
        load_req = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            run_entry(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                $display("test %0d %s: %0d errors", steps[i].test, test_name[steps[i].test],
                         test_errors);
                test_errors = 0;
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/emu_ctrl_sva.sv ====
`timescale 1ns/1ps

module emu_ctrl_sva (
    input logic             host_clk,
    input logic             host_rst,
    input emu_pkg::wb_req_t wb_req,
    input emu_pkg::wb_rsp_t wb_rsp,
    input logic             ff_se
);

    // Classic cycle ack is a single-cycle pulse
    ack_pulse: assert property (@(posedge host_clk) disable iff (host_rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack stayed high for more than one cycle");

    ack_in_cycle: assert property (@(posedge host_clk) disable iff (host_rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else $error("ack raised outside a bus cycle");

    // One shift per chain word
    se_length: assert property (@(posedge host_clk) disable iff (host_rst)
        $rose(ff_se) |-> ff_se [*emu_pkg::FF_COUNT] ##1 !ff_se)
        else $error("ff_se did not last exactly FF_COUNT cycles");

endmodule

bind emu_ctrl emu_ctrl_sva i_sva (
    .host_clk (host_clk),
    .host_rst (host_rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .ff_se    (ff_se)
);

// ==== src/emu_ctrl.sv ====
`timescale 1ns/1ps

module emu_ctrl (
    input  logic                             host_clk,
    input  logic                             host_rst,
    input  emu_pkg::wb_req_t                 wb_req,
    output emu_pkg::wb_rsp_t                 wb_rsp,
    input  logic                             tick,
    input  logic [63:0]                      ff_do,
    input  logic [emu_pkg::TRIG_COUNT-1:0]   trig,
    output logic                             run_mode,
    output logic                             scan_mode,
    output logic                             ff_se,
    output logic [63:0]                      ff_di,
    output logic [emu_pkg::RESET_COUNT-1:0]  model_rst
);

    emu_pkg::csr_req_t  csr_req;
    emu_pkg::scan_cmd_t scan_cmd;
    logic [31:0]        csr_rdata;
    logic [31:0]        buf_rdata;
    logic               scan_busy;

    wb_csr_bridge i_bridge (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .wb_req    (wb_req),
        .csr_rdata (csr_rdata),
        .wb_rsp    (wb_rsp),
        .csr_req   (csr_req)
    );

    emu_csr_regs i_regs (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .csr_req   (csr_req),
        .tick      (tick),
        .trig      (trig),
        .scan_busy (scan_busy),
        .buf_rdata (buf_rdata),
        .csr_rdata (csr_rdata),
        .run_mode  (run_mode),
        .scan_mode (scan_mode),
        .model_rst (model_rst),
        .scan_cmd  (scan_cmd)
    );

    scan_chain_ctrl i_scan (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .scan_cmd  (scan_cmd),
        .ff_do     (ff_do),
        .ff_se     (ff_se),
        .ff_di     (ff_di),
        .scan_busy (scan_busy),
        .buf_rdata (buf_rdata)
    );

endmodule

// ==== src/scan_chain_ctrl.sv ====
`timescale 1ns/1ps

module scan_chain_ctrl (
    input  logic               host_clk,
    input  logic               host_rst,
    input  emu_pkg::scan_cmd_t scan_cmd,
    input  logic [63:0]        ff_do,
    output logic               ff_se,
    output logic [63:0]        ff_di,
    output logic               scan_busy,
    output logic [31:0]        buf_rdata
);

    logic [63:0]                   snap [emu_pkg::FF_COUNT];
    logic [emu_pkg::FF_IDX_W-1:0]  shift_cnt;
    logic                          busy;
    logic                          restore;
    logic [emu_pkg::FF_IDX_W-1:0]  buf_word;
    logic                          buf_half;

    assign buf_word = scan_cmd.buf_idx[emu_pkg::FF_IDX_W:1];
    assign buf_half = scan_cmd.buf_idx[0];

    // Sequencer, a start while busy is dropped
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            busy      <= 1'b0;
            restore   <= 1'b0;
            shift_cnt <= '0;
        end else if (busy) begin
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == emu_pkg::FF_LAST) begin
                busy <= 1'b0;
            end
        end else if (scan_cmd.start) begin
            busy      <= 1'b1;
            restore   <= scan_cmd.direction;
            shift_cnt <= '0;
        end
    end

    // Snapshot buffer
    // Capture owns it during a scan, the host only when idle
    always_ff @(posedge host_clk) begin
        if (busy) begin
            if (!restore) begin
                snap[shift_cnt] <= ff_do;
            end
        end else if (scan_cmd.buf_wen) begin
            if (buf_half) begin
                snap[buf_word][63:32] <= scan_cmd.buf_wdata;
            end else begin
                snap[buf_word][31:0] <= scan_cmd.buf_wdata;
            end
        end
    end

    assign buf_rdata = buf_half ? snap[buf_word][63:32] : snap[buf_word][31:0];

    // Capture loops the chain back on itself
    assign ff_di     = restore ? snap[shift_cnt] : ff_do;
    assign ff_se     = busy;
    assign scan_busy = busy;

endmodule

// ==== src/emu_csr_regs.sv ====
`timescale 1ns/1ps

module emu_csr_regs (
    input  logic                             host_clk,
    input  logic                             host_rst,
    input  emu_pkg::csr_req_t                csr_req,
    input  logic                             tick,
    input  logic [emu_pkg::TRIG_COUNT-1:0]   trig,
    input  logic                             scan_busy,
    input  logic [31:0]                      buf_rdata,
    output logic [31:0]                      csr_rdata,
    output logic                             run_mode,
    output logic                             scan_mode,
    output logic [emu_pkg::RESET_COUNT-1:0]  model_rst,
    output emu_pkg::scan_cmd_t               scan_cmd
);

    logic                            sel_run;
    logic                            sel_step;
    logic                            sel_cnt_lo;
    logic                            sel_cnt_hi;
    logic                            sel_scan;
    logic                            sel_trig_stat;
    logic                            sel_trig_en;
    logic                            sel_reset;
    logic                            sel_scan_data;
    logic [1:0]                      bank;

    logic                            resume_req;
    logic                            req_next;
    logic                            trig_hit;
    logic                            pause_now;
    logic [31:0]                     tick_step;
    logic [63:0]                     tick_cnt;
    logic [emu_pkg::TRIG_COUNT-1:0]  trig_stat;
    logic [emu_pkg::TRIG_COUNT-1:0]  trig_en;

    logic [emu_pkg::BANK_BITS-1:0]   trig_stat_ext;
    logic [emu_pkg::BANK_BITS-1:0]   trig_en_ext;
    logic [emu_pkg::BANK_BITS-1:0]   reset_ext;

    // Address decode
    assign sel_run       = csr_req.addr == emu_pkg::RUN_CTRL;
    assign sel_step      = csr_req.addr == emu_pkg::TICK_STEP;
    assign sel_cnt_lo    = csr_req.addr == emu_pkg::TICK_CNT_LO;
    assign sel_cnt_hi    = csr_req.addr == emu_pkg::TICK_CNT_HI;
    assign sel_scan      = csr_req.addr == emu_pkg::SCAN_CTRL;
    assign sel_trig_stat = csr_req.addr[emu_pkg::CSR_AW-1:2] == emu_pkg::TRIG_STAT[emu_pkg::CSR_AW-1:2];
    assign sel_trig_en   = csr_req.addr[emu_pkg::CSR_AW-1:2] == emu_pkg::TRIG_EN[emu_pkg::CSR_AW-1:2];
    assign sel_reset     = csr_req.addr[emu_pkg::CSR_AW-1:2] == emu_pkg::RESET_CTRL[emu_pkg::CSR_AW-1:2];
    assign sel_scan_data = csr_req.addr[emu_pkg::CSR_AW-1:emu_pkg::FF_IDX_W+1]
                        == emu_pkg::SCAN_DATA[emu_pkg::CSR_AW-1:emu_pkg::FF_IDX_W+1];
    assign bank          = csr_req.addr[1:0];

    // Run control
    assign req_next  = (csr_req.wen && sel_run) ? csr_req.wdata[0] : resume_req;
    assign trig_hit  = |(trig & trig_en);
    assign pause_now = run_mode && tick && (!resume_req || trig_hit || tick_step == 32'd1);

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            resume_req <= 1'b0;
            run_mode   <= 1'b0;
            scan_mode  <= 1'b0;
        end else begin
            // A pause consumes the resume request
            resume_req <= (pause_now && !(csr_req.wen && sel_run)) ? 1'b0 : req_next;
            if (!run_mode) begin
                run_mode <= req_next;
            end else if (pause_now) begin
                run_mode <= 1'b0;
            end
            if (csr_req.wen && sel_run) begin
                scan_mode <= csr_req.wdata[1];
            end
        end
    end

    // Step budget and tick counter, host writes only while paused
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_step <= 32'd0;
            tick_cnt  <= 64'd0;
        end else if (run_mode) begin
            if (tick) begin
                tick_cnt <= tick_cnt + 64'd1;
                if (tick_step != 32'd0) begin
                    tick_step <= tick_step - 32'd1;
                end
            end
        end else if (csr_req.wen) begin
            if (sel_step) begin
                tick_step <= csr_req.wdata;
            end
            if (sel_cnt_lo) begin
                tick_cnt[31:0] <= csr_req.wdata;
            end
            if (sel_cnt_hi) begin
                tick_cnt[63:32] <= csr_req.wdata;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_stat <= '0;
        end else if (run_mode) begin
            trig_stat <= trig;
        end
    end

    // Bank writes, one 32-bit word per access
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_en   <= '0;
            model_rst <= '0;
        end else if (csr_req.wen) begin
            for (int i = 0; i < emu_pkg::TRIG_COUNT; i++) begin
                if (sel_trig_en && bank == 2'(i / 32)) begin
                    trig_en[i] <= csr_req.wdata[i % 32];
                end
            end
            for (int i = 0; i < emu_pkg::RESET_COUNT; i++) begin
                if (sel_reset && bank == 2'(i / 32)) begin
                    model_rst[i] <= csr_req.wdata[i % 32];
                end
            end
        end
    end

    // Unused bank bits read as zero
    assign trig_stat_ext = {{(emu_pkg::BANK_BITS-emu_pkg::TRIG_COUNT){1'b0}}, trig_stat};
    assign trig_en_ext   = {{(emu_pkg::BANK_BITS-emu_pkg::TRIG_COUNT){1'b0}}, trig_en};
    assign reset_ext     = {{(emu_pkg::BANK_BITS-emu_pkg::RESET_COUNT){1'b0}}, model_rst};

    // Scan sequencer commands
    assign scan_cmd.start     = csr_req.wen && sel_scan && csr_req.wdata[0];
    assign scan_cmd.direction = csr_req.wdata[1];
    assign scan_cmd.buf_wen   = csr_req.wen && sel_scan_data;
    assign scan_cmd.buf_idx   = csr_req.addr[emu_pkg::FF_IDX_W:0];
    assign scan_cmd.buf_wdata = csr_req.wdata;

    always_comb begin
        csr_rdata = 32'd0;
        if (sel_run) begin
            csr_rdata = {30'd0, scan_mode, run_mode};
        end else if (sel_step) begin
            csr_rdata = tick_step;
        end else if (sel_cnt_lo) begin
            csr_rdata = tick_cnt[31:0];
        end else if (sel_cnt_hi) begin
            csr_rdata = tick_cnt[63:32];
        end else if (sel_scan) begin
            csr_rdata = {31'd0, scan_busy};
        end else if (sel_trig_stat) begin
            csr_rdata = trig_stat_ext[bank*32 +: 32];
        end else if (sel_trig_en) begin
            csr_rdata = trig_en_ext[bank*32 +: 32];
        end else if (sel_reset) begin
            csr_rdata = reset_ext[bank*32 +: 32];
        end else if (sel_scan_data) begin
            csr_rdata = buf_rdata;
        end
    end

endmodule

// ==== src/wb_csr_bridge.sv ====
`timescale 1ns/1ps

module wb_csr_bridge (
    input  logic              host_clk,
    input  logic              host_rst,
    input  emu_pkg::wb_req_t  wb_req,
    input  logic [31:0]       csr_rdata,
    output emu_pkg::wb_rsp_t  wb_rsp,
    output emu_pkg::csr_req_t csr_req
);

    logic        ack;
    logic [31:0] dat_r;
    logic        access;

    // New access seen while no ack is pending
    assign access = wb_req.cyc && wb_req.stb && !ack;

    assign csr_req.wen   = access && wb_req.we;
    assign csr_req.ren   = access && !wb_req.we;
    // Byte address to word address
    assign csr_req.addr  = wb_req.adr[emu_pkg::WB_AW-1:2];
    assign csr_req.wdata = wb_req.dat_w;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // Read data is captured alongside the ack
    always_ff @(posedge host_clk) begin
        if (csr_req.ren) begin
            dat_r <= csr_rdata;
        end
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = dat_r;

endmodule

// ==== src/emu_pkg.sv ====
package emu_pkg;

    // Model-side sizes
    localparam int TRIG_COUNT  = 48;
    localparam int RESET_COUNT = 16;
    localparam int FF_COUNT    = 4;

    // Snapshot word index width and last shift count
    localparam int FF_IDX_W = $clog2(FF_COUNT);
    localparam logic [FF_IDX_W-1:0] FF_LAST = FF_IDX_W'(FF_COUNT - 1);

    // Four 32-bit words per trigger or reset bank
    localparam int BANK_BITS = 128;

    localparam int WB_AW  = 12;
    localparam int CSR_AW = 10;

    // Register word offsets
    localparam logic [CSR_AW-1:0] RUN_CTRL    = 10'h000;
    localparam logic [CSR_AW-1:0] TICK_STEP   = 10'h001;
    localparam logic [CSR_AW-1:0] TICK_CNT_LO = 10'h002;
    localparam logic [CSR_AW-1:0] TICK_CNT_HI = 10'h003;
    localparam logic [CSR_AW-1:0] SCAN_CTRL   = 10'h004;
    localparam logic [CSR_AW-1:0] TRIG_STAT   = 10'h040;
    localparam logic [CSR_AW-1:0] TRIG_EN     = 10'h044;
    localparam logic [CSR_AW-1:0] RESET_CTRL  = 10'h048;
    localparam logic [CSR_AW-1:0] SCAN_DATA   = 10'h080;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [31:0]      dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic              wen;
        logic              ren;
        logic [CSR_AW-1:0] addr;
        logic [31:0]       wdata;
    } csr_req_t;

    // buf_idx is {word, half}, half 0 is the low 32 bits
    typedef struct packed {
        logic              start;
        logic              direction;
        logic              buf_wen;
        logic [FF_IDX_W:0] buf_idx;
        logic [31:0]       buf_wdata;
    } scan_cmd_t;

endpackage
